// File: hw/cart_pkg.sv
`default_nettype none

package cart_pkg;

	localparam int rom_addr_w     = 24;
	localparam int map_rom_addr_w = 23; // coprocessors see 8 MB
	localparam int rom_data_w     = 16;
	localparam int bsram_addr_w   = 20;
	localparam int aram_addr_w    = 16;
	localparam int data_w         = 8;
	localparam int num_slots      = 3;

	typedef logic [num_slots-1:0] map_vec_t;

	// index of a coprocessor in map_vec_t, dlh is the fallback
	typedef enum logic [1:0] {
		slot_gsu  = 2'd0,
		slot_sa1  = 2'd1,
		slot_sdd1 = 2'd2,
		slot_dlh  = 2'd3
	} slot_e;

	typedef struct packed {
		logic [rom_addr_w-1:0] addr;
		logic                  ce_n;
		logic                  oe_n;
		logic                  word; // 16-bit fetch
	} rom_req_t;

	typedef struct packed {
		logic [bsram_addr_w-1:0] addr;
		logic [data_w-1:0]       d;
		logic                    ce_n;
		logic                    oe_n;
		logic                    we_n;
	} bsram_req_t;

	typedef struct packed {
		logic [data_w-1:0] d;
		logic              irq_n;
	} cpu_resp_t;

endpackage

`default_nettype wire

// File: hw/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// async SRAM style port, strobes active low, no handshake
interface mem_bus #(
	parameter int addr_w = 16
);

	logic [addr_w-1:0]          addr;
	logic [cart_pkg::data_w-1:0] d;
	logic                       ce_n;
	logic                       oe_n;
	logic                       we_n;

	modport master (
		output addr, d, ce_n, oe_n, we_n
	);

	modport slave (
		input addr, d, ce_n, oe_n, we_n
	);

endinterface

`default_nettype wire

// File: hw/map_control.sv
`timescale 1ns/1ps
`default_nettype none

module map_control (
	input  logic               mclk,
	input  logic               rst_n,
	input  cart_pkg::map_vec_t map_active,
	input  logic [7:0]         rom_type,
	input  logic               ss_busy,
	output cart_pkg::slot_e    sel,
	output logic               ss_avail,
	output logic               turbo_allow
);

	cart_pkg::slot_e sel_nxt;

	always_comb begin
		sel_nxt = cart_pkg::slot_dlh; // zero or several active
		if ($onehot(map_active)) begin
			for (int i = 0; i < cart_pkg::num_slots; i++) begin
				if (map_active[i]) begin
					sel_nxt = cart_pkg::slot_e'(i);
				end
			end
		end
	end

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			sel <= cart_pkg::slot_dlh;
		end else begin
			sel <= sel_nxt;
		end
	end

	// plain carts, dspn carts, sa1 and gsu can be saved
	assign ss_avail = ~|rom_type[7:4] | (rom_type[7:6] == 2'b10) |
		map_active[cart_pkg::slot_sa1] | map_active[cart_pkg::slot_gsu];

	assign turbo_allow = ~(map_active[cart_pkg::slot_sa1] |
		map_active[cart_pkg::slot_sdd1] | ss_busy);

endmodule

`default_nettype wire

// File: hw/map_onehot_mux.sv
`timescale 1ns/1ps
`default_nettype none

module map_onehot_mux #(
	parameter type payload_t = logic
) (
	input  cart_pkg::slot_e sel,
	input  payload_t        dflt,
	input  payload_t        slots [cart_pkg::num_slots],
	output payload_t        y
);

	// sel is already decoded, slot_dlh matches no slot
	always_comb begin
		y = dflt;
		for (int i = 0; i < cart_pkg::num_slots; i++) begin
			if (sel == cart_pkg::slot_e'(i)) begin
				y = slots[i];
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/cart_port_select.sv
`timescale 1ns/1ps
`default_nettype none

module cart_port_select (
	input  cart_pkg::slot_e                 sel,
	input  cart_pkg::rom_req_t              dlh_rom,
	input  cart_pkg::rom_req_t              slot_rom [cart_pkg::num_slots],
	input  cart_pkg::bsram_req_t            dlh_bsram,
	input  cart_pkg::bsram_req_t            slot_bsram [cart_pkg::num_slots],
	input  cart_pkg::cpu_resp_t             dlh_resp,
	input  cart_pkg::cpu_resp_t             slot_resp [cart_pkg::num_slots],
	input  logic                            msu_sel,
	input  logic [cart_pkg::data_w-1:0]     msu_do,
	input  logic                            ss_do_ovr,
	input  logic                            ss_rom_ovr,
	input  logic [cart_pkg::data_w-1:0]     ss_do,
	input  logic [cart_pkg::rom_addr_w-1:0] ss_rom_addr,
	output cart_pkg::rom_req_t              rom,
	mem_bus.master                          bsram,
	output logic [cart_pkg::data_w-1:0]     cpu_di,
	output logic                            irq_n
);

	cart_pkg::rom_req_t   rom_ext [cart_pkg::num_slots];
	cart_pkg::rom_req_t   rom_map;
	cart_pkg::bsram_req_t bsram_map;
	cart_pkg::cpu_resp_t  resp_map;

	// coprocessors only reach the lower half of the rom space
	always_comb begin
		for (int i = 0; i < cart_pkg::num_slots; i++) begin
			rom_ext[i]      = slot_rom[i];
			rom_ext[i].addr = cart_pkg::rom_addr_w'(
				slot_rom[i].addr[cart_pkg::map_rom_addr_w-1:0]);
		end
	end

	map_onehot_mux #(.payload_t(cart_pkg::rom_req_t)) u_rom_mux (
		.sel   (sel),
		.dflt  (dlh_rom),
		.slots (rom_ext),
		.y     (rom_map)
	);

	map_onehot_mux #(.payload_t(cart_pkg::bsram_req_t)) u_bsram_mux (
		.sel   (sel),
		.dflt  (dlh_bsram),
		.slots (slot_bsram),
		.y     (bsram_map)
	);

	map_onehot_mux #(.payload_t(cart_pkg::cpu_resp_t)) u_resp_mux (
		.sel   (sel),
		.dflt  (dlh_resp),
		.slots (slot_resp),
		.y     (resp_map)
	);

	always_comb begin
		rom = rom_map;
		if (ss_rom_ovr) begin
			rom.addr = ss_rom_addr;
		end
	end

	always_comb begin
		cpu_di = resp_map.d;
		if (msu_sel) begin
			cpu_di = msu_do;
		end
		if (ss_do_ovr) begin
			cpu_di = ss_do; // save state wins over msu
		end
	end

	assign irq_n = resp_map.irq_n;

	assign bsram.addr = bsram_map.addr;
	assign bsram.d    = bsram_map.d;
	assign bsram.ce_n = bsram_map.ce_n;
	assign bsram.oe_n = bsram_map.oe_n;
	assign bsram.we_n = bsram_map.we_n;

endmodule

`default_nettype wire

// File: hw/ss_mem_override.sv
`timescale 1ns/1ps
`default_nettype none

module ss_mem_override #(
	parameter int addr_w = 16
) (
	mem_bus.slave                       core,
	input  logic                        ss_sel,
	input  logic [addr_w-1:0]           ss_addr,
	input  logic [cart_pkg::data_w-1:0] ss_do,
	input  logic                        pard_n,
	input  logic                        pawr_n,
	mem_bus.master                      mem
);

	always_comb begin
		if (ss_sel) begin
			// engine moves data over the peripheral bus strobes
			mem.addr = ss_addr;
			mem.d    = ss_do;
			mem.ce_n = 1'b0;
			mem.oe_n = pard_n;
			mem.we_n = pawr_n;
		end else begin
			mem.addr = core.addr;
			mem.d    = core.d;
			mem.ce_n = core.ce_n;
			mem.oe_n = core.oe_n;
			mem.we_n = core.we_n;
		end
	end

endmodule

`default_nettype wire

// File: hw/cart_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module cart_bus_top (
	input  logic                                 mclk,
	input  logic                                 rst_n,
	input  cart_pkg::map_vec_t                   map_active,
	input  logic [7:0]                           rom_type,
	input  logic                                 ss_busy,

	input  logic [cart_pkg::rom_addr_w-1:0]      dlh_rom_addr,
	input  logic                                 dlh_rom_ce_n,
	input  logic                                 dlh_rom_oe_n,
	input  logic                                 dlh_rom_word,
	input  logic [cart_pkg::bsram_addr_w-1:0]    dlh_bsram_addr,
	input  logic [cart_pkg::data_w-1:0]          dlh_bsram_d,
	input  logic                                 dlh_bsram_ce_n,
	input  logic                                 dlh_bsram_oe_n,
	input  logic                                 dlh_bsram_we_n,
	input  logic [cart_pkg::data_w-1:0]          dlh_do,
	input  logic                                 dlh_irq_n,

	input  logic [cart_pkg::num_slots-1:0][cart_pkg::map_rom_addr_w-1:0] slot_rom_addr,
	input  logic [cart_pkg::num_slots-1:0]       slot_rom_ce_n,
	input  logic [cart_pkg::num_slots-1:0]       slot_rom_oe_n,
	input  logic [cart_pkg::num_slots-1:0]       slot_rom_word,
	input  logic [cart_pkg::num_slots-1:0][cart_pkg::bsram_addr_w-1:0] slot_bsram_addr,
	input  logic [cart_pkg::num_slots-1:0][cart_pkg::data_w-1:0] slot_bsram_d,
	input  logic [cart_pkg::num_slots-1:0]       slot_bsram_ce_n,
	input  logic [cart_pkg::num_slots-1:0]       slot_bsram_oe_n,
	input  logic [cart_pkg::num_slots-1:0]       slot_bsram_we_n,
	input  logic [cart_pkg::num_slots-1:0][cart_pkg::data_w-1:0] slot_do,
	input  logic [cart_pkg::num_slots-1:0]       slot_irq_n,

	input  logic                                 msu_sel,
	input  logic [cart_pkg::data_w-1:0]          msu_do,

	input  logic [cart_pkg::data_w-1:0]          ss_do,
	input  logic                                 ss_do_ovr,
	input  logic                                 ss_rom_ovr,
	input  logic [cart_pkg::rom_addr_w-1:0]      ss_rom_addr,
	input  logic [cart_pkg::bsram_addr_w-1:0]    ss_ext_addr,
	input  logic                                 ss_bsram_sel,
	input  logic                                 ss_aram_sel,
	input  logic                                 pard_n,
	input  logic                                 pawr_n,

	input  logic [cart_pkg::aram_addr_w-1:0]     aram_core_addr,
	input  logic [cart_pkg::data_w-1:0]          aram_core_d,
	input  logic                                 aram_core_ce_n,
	input  logic                                 aram_core_oe_n,
	input  logic                                 aram_core_we_n,

	output logic [cart_pkg::rom_addr_w-1:0]      rom_addr,
	output logic                                 rom_ce_n,
	output logic                                 rom_oe_n,
	output logic                                 rom_word,
	output logic [cart_pkg::bsram_addr_w-1:0]    bsram_addr,
	output logic [cart_pkg::data_w-1:0]          bsram_d,
	output logic                                 bsram_ce_n,
	output logic                                 bsram_oe_n,
	output logic                                 bsram_we_n,
	output logic [cart_pkg::aram_addr_w-1:0]     aram_addr,
	output logic [cart_pkg::data_w-1:0]          aram_d,
	output logic                                 aram_ce_n,
	output logic                                 aram_oe_n,
	output logic                                 aram_we_n,
	output logic [cart_pkg::data_w-1:0]          cpu_di,
	output logic                                 irq_n,
	output logic                                 ss_avail,
	output logic                                 turbo_allow
);

	cart_pkg::slot_e      sel;
	cart_pkg::rom_req_t   dlh_rom;
	cart_pkg::rom_req_t   slot_rom [cart_pkg::num_slots];
	cart_pkg::bsram_req_t dlh_bsram;
	cart_pkg::bsram_req_t slot_bsram [cart_pkg::num_slots];
	cart_pkg::cpu_resp_t  dlh_resp;
	cart_pkg::cpu_resp_t  slot_resp [cart_pkg::num_slots];
	cart_pkg::rom_req_t   rom_out;

	mem_bus #(.addr_w(cart_pkg::bsram_addr_w)) bsram_core ();
	mem_bus #(.addr_w(cart_pkg::bsram_addr_w)) bsram_mem ();
	mem_bus #(.addr_w(cart_pkg::aram_addr_w))  aram_core ();
	mem_bus #(.addr_w(cart_pkg::aram_addr_w))  aram_mem ();

	assign dlh_rom   = '{dlh_rom_addr, dlh_rom_ce_n, dlh_rom_oe_n, dlh_rom_word};
	assign dlh_bsram = '{dlh_bsram_addr, dlh_bsram_d, dlh_bsram_ce_n, dlh_bsram_oe_n,
		dlh_bsram_we_n};
	assign dlh_resp  = '{dlh_do, dlh_irq_n};

	for (genvar i = 0; i < cart_pkg::num_slots; i++) begin : g_slot
		assign slot_rom[i] = '{cart_pkg::rom_addr_w'(slot_rom_addr[i]), slot_rom_ce_n[i],
			slot_rom_oe_n[i], slot_rom_word[i]};
		assign slot_bsram[i] = '{slot_bsram_addr[i], slot_bsram_d[i], slot_bsram_ce_n[i],
			slot_bsram_oe_n[i], slot_bsram_we_n[i]};
		assign slot_resp[i] = '{slot_do[i], slot_irq_n[i]};
	end

	assign aram_core.addr = aram_core_addr;
	assign aram_core.d    = aram_core_d;
	assign aram_core.ce_n = aram_core_ce_n;
	assign aram_core.oe_n = aram_core_oe_n;
	assign aram_core.we_n = aram_core_we_n;

	map_control u_map_control (
		.mclk        (mclk),
		.rst_n       (rst_n),
		.map_active  (map_active),
		.rom_type    (rom_type),
		.ss_busy     (ss_busy),
		.sel         (sel),
		.ss_avail    (ss_avail),
		.turbo_allow (turbo_allow)
	);

	cart_port_select u_cart_port_select (
		.sel         (sel),
		.dlh_rom     (dlh_rom),
		.slot_rom    (slot_rom),
		.dlh_bsram   (dlh_bsram),
		.slot_bsram  (slot_bsram),
		.dlh_resp    (dlh_resp),
		.slot_resp   (slot_resp),
		.msu_sel     (msu_sel),
		.msu_do      (msu_do),
		.ss_do_ovr   (ss_do_ovr),
		.ss_rom_ovr  (ss_rom_ovr),
		.ss_do       (ss_do),
		.ss_rom_addr (ss_rom_addr),
		.rom         (rom_out),
		.bsram       (bsram_core),
		.cpu_di      (cpu_di),
		.irq_n       (irq_n)
	);

	ss_mem_override #(.addr_w(cart_pkg::bsram_addr_w)) u_bsram_override (
		.core    (bsram_core),
		.ss_sel  (ss_bsram_sel),
		.ss_addr (ss_ext_addr),
		.ss_do   (ss_do),
		.pard_n  (pard_n),
		.pawr_n  (pawr_n),
		.mem     (bsram_mem)
	);

	ss_mem_override #(.addr_w(cart_pkg::aram_addr_w)) u_aram_override (
		.core    (aram_core),
		.ss_sel  (ss_aram_sel),
		.ss_addr (ss_ext_addr[cart_pkg::aram_addr_w-1:0]), // aram is 64k
		.ss_do   (ss_do),
		.pard_n  (pard_n),
		.pawr_n  (pawr_n),
		.mem     (aram_mem)
	);

	assign rom_addr   = rom_out.addr;
	assign rom_ce_n   = rom_out.ce_n;
	assign rom_oe_n   = rom_out.oe_n;
	assign rom_word   = rom_out.word;

	assign bsram_addr = bsram_mem.addr;
	assign bsram_d    = bsram_mem.d;
	assign bsram_ce_n = bsram_mem.ce_n;
	assign bsram_oe_n = bsram_mem.oe_n;
	assign bsram_we_n = bsram_mem.we_n;

	assign aram_addr  = aram_mem.addr;
	assign aram_d     = aram_mem.d;
	assign aram_ce_n  = aram_mem.ce_n;
	assign aram_oe_n  = aram_mem.oe_n;
	assign aram_we_n  = aram_mem.we_n;

endmodule

`default_nettype wire

// File: verification/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
	parameter int period_ns = 4
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: verification/cart_bus_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cart_bus_properties (
	input logic mclk,
	input logic rst_n,
	input logic ss_busy,
	input logic ss_bsram_sel,
	input logic ss_aram_sel,
	input logic bsram_ce_n,
	input logic aram_ce_n,
	input logic turbo_allow
);

	a_aram_ss_ce: assert property (@(posedge mclk) disable iff (!rst_n)
		ss_aram_sel |-> !aram_ce_n)
		else $error("aram_ce_n high while the save-state engine owns aram");

	a_bsram_ss_ce: assert property (@(posedge mclk) disable iff (!rst_n)
		ss_bsram_sel |-> !bsram_ce_n)
		else $error("bsram_ce_n high while the save-state engine owns bsram");

	// turbo must stay off for the whole save-state transfer
	a_turbo_busy: assert property (@(posedge mclk) disable iff (!rst_n)
		ss_busy |-> !turbo_allow)
		else $error("turbo_allow high while ss_busy is set");

endmodule

`default_nettype wire

// File: verification/cart_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cart_bus_tb;

	localparam int clk_period     = 4;
	localparam int reset_cycles   = 4;
	localparam int num_cycles     = 2000;
	localparam int timeout_ns     = (num_cycles + reset_cycles) * clk_period * 3 / 2;
	localparam int rom_addr_w     = cart_pkg::rom_addr_w;
	localparam int map_rom_addr_w = cart_pkg::map_rom_addr_w;
	localparam int bsram_addr_w   = cart_pkg::bsram_addr_w;
	localparam int aram_addr_w    = cart_pkg::aram_addr_w;
	localparam int data_w         = cart_pkg::data_w;
	localparam int num_slots      = cart_pkg::num_slots;
	localparam int idx_gsu        = 0;
	localparam int idx_sa1        = 1;
	localparam int idx_sdd1       = 2;
	localparam int sel_dlh        = 3; // model value for the default mapper

	logic mclk;
	logic rst_n;
	logic [num_slots-1:0] map_active;
	logic [7:0] rom_type;
	logic ss_busy;
	logic [rom_addr_w-1:0] dlh_rom_addr;
	logic dlh_rom_ce_n, dlh_rom_oe_n, dlh_rom_word;
	logic [bsram_addr_w-1:0] dlh_bsram_addr;
	logic [data_w-1:0] dlh_bsram_d, dlh_do;
	logic dlh_bsram_ce_n, dlh_bsram_oe_n, dlh_bsram_we_n, dlh_irq_n;
	logic [num_slots-1:0][map_rom_addr_w-1:0] slot_rom_addr;
	logic [num_slots-1:0] slot_rom_ce_n, slot_rom_oe_n, slot_rom_word;
	logic [num_slots-1:0][bsram_addr_w-1:0] slot_bsram_addr;
	logic [num_slots-1:0][data_w-1:0] slot_bsram_d, slot_do;
	logic [num_slots-1:0] slot_bsram_ce_n, slot_bsram_oe_n, slot_bsram_we_n, slot_irq_n;
	logic msu_sel, ss_do_ovr, ss_rom_ovr, ss_bsram_sel, ss_aram_sel, pard_n, pawr_n;
	logic [data_w-1:0] msu_do, ss_do, aram_core_d;
	logic [rom_addr_w-1:0] ss_rom_addr;
	logic [bsram_addr_w-1:0] ss_ext_addr;
	logic [aram_addr_w-1:0] aram_core_addr;
	logic aram_core_ce_n, aram_core_oe_n, aram_core_we_n;
	logic [rom_addr_w-1:0] rom_addr;
	logic rom_ce_n, rom_oe_n, rom_word;
	logic [bsram_addr_w-1:0] bsram_addr;
	logic [data_w-1:0] bsram_d, aram_d, cpu_di;
	logic bsram_ce_n, bsram_oe_n, bsram_we_n;
	logic [aram_addr_w-1:0] aram_addr;
	logic aram_ce_n, aram_oe_n, aram_we_n, irq_n, ss_avail, turbo_allow;

	logic [31:0] lfsr_state;
	int model_sel; // selection the DUT registered at the last edge

	clk_gen #(.period_ns(clk_period)) u_clk_gen (.clk(mclk));

	cart_bus_top u_cart_bus_top (.*);

	bind cart_bus_top cart_bus_properties u_cart_bus_properties (
		.mclk         (mclk),
		.rst_n        (rst_n),
		.ss_busy      (ss_busy),
		.ss_bsram_sel (ss_bsram_sel),
		.ss_aram_sel  (ss_aram_sel),
		.bsram_ce_n   (bsram_ce_n),
		.aram_ce_n    (aram_ce_n),
		.turbo_allow  (turbo_allow)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int decode_sel(input logic [num_slots-1:0] v);
		case (v)
			3'b001:  return idx_gsu;
			3'b010:  return idx_sa1;
			3'b100:  return idx_sdd1;
			default: return sel_dlh; // zero or several mappers
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("Verification failed");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic drive_inputs(input int cycle);
		if (cycle % 16 == 0) begin
			map_active = num_slots'(rand_bits(num_slots));
		end
		rom_type       = 8'(rand_bits(8));
		ss_busy        = 1'(rand_bits(1));
		dlh_rom_addr   = rom_addr_w'(rand_bits(rom_addr_w));
		dlh_rom_ce_n   = 1'(rand_bits(1));
		dlh_rom_oe_n   = 1'(rand_bits(1));
		dlh_rom_word   = 1'(rand_bits(1));
		dlh_bsram_addr = bsram_addr_w'(rand_bits(bsram_addr_w));
		dlh_bsram_d    = data_w'(rand_bits(data_w));
		dlh_bsram_ce_n = 1'(rand_bits(1));
		dlh_bsram_oe_n = 1'(rand_bits(1));
		dlh_bsram_we_n = 1'(rand_bits(1));
		dlh_do         = data_w'(rand_bits(data_w));
		dlh_irq_n      = 1'(rand_bits(1));
		for (int i = 0; i < num_slots; i++) begin
			slot_rom_addr[i]   = map_rom_addr_w'(rand_bits(map_rom_addr_w));
			slot_rom_ce_n[i]   = 1'(rand_bits(1));
			slot_rom_oe_n[i]   = 1'(rand_bits(1));
			slot_rom_word[i]   = 1'(rand_bits(1));
			slot_bsram_addr[i] = bsram_addr_w'(rand_bits(bsram_addr_w));
			slot_bsram_d[i]    = data_w'(rand_bits(data_w));
			slot_bsram_ce_n[i] = 1'(rand_bits(1));
			slot_bsram_oe_n[i] = 1'(rand_bits(1));
			slot_bsram_we_n[i] = 1'(rand_bits(1));
			slot_do[i]         = data_w'(rand_bits(data_w));
			slot_irq_n[i]      = 1'(rand_bits(1));
		end
		msu_sel        = (rand_bits(2) == 32'd0); // overrides a quarter of the time
		msu_do         = data_w'(rand_bits(data_w));
		ss_do_ovr      = (rand_bits(2) == 32'd0);
		ss_rom_ovr     = (rand_bits(2) == 32'd0);
		ss_bsram_sel   = (rand_bits(2) == 32'd0);
		ss_aram_sel    = (rand_bits(2) == 32'd0);
		ss_do          = data_w'(rand_bits(data_w));
		ss_rom_addr    = rom_addr_w'(rand_bits(rom_addr_w));
		ss_ext_addr    = bsram_addr_w'(rand_bits(bsram_addr_w));
		pard_n         = 1'(rand_bits(1));
		pawr_n         = 1'(rand_bits(1));
		aram_core_addr = aram_addr_w'(rand_bits(aram_addr_w));
		aram_core_d    = data_w'(rand_bits(data_w));
		aram_core_ce_n = 1'(rand_bits(1));
		aram_core_oe_n = 1'(rand_bits(1));
		aram_core_we_n = 1'(rand_bits(1));
	endtask

	task automatic check_outputs();
		logic [rom_addr_w-1:0] e_rom_addr;
		logic e_rom_ce_n, e_rom_oe_n, e_rom_word;
		logic [bsram_addr_w-1:0] e_bs_addr;
		logic [data_w-1:0] e_bs_d, e_ar_d, e_cpu_di;
		logic e_bs_ce_n, e_bs_oe_n, e_bs_we_n, e_irq_n;
		logic [aram_addr_w-1:0] e_ar_addr;
		logic e_ar_ce_n, e_ar_oe_n, e_ar_we_n, e_ss_avail, e_turbo;
		if (model_sel == sel_dlh) begin
			e_rom_addr = dlh_rom_addr;
			{e_rom_ce_n, e_rom_oe_n, e_rom_word} = {dlh_rom_ce_n, dlh_rom_oe_n, dlh_rom_word};
			{e_bs_addr, e_bs_d} = {dlh_bsram_addr, dlh_bsram_d};
			{e_bs_ce_n, e_bs_oe_n, e_bs_we_n} = {dlh_bsram_ce_n, dlh_bsram_oe_n, dlh_bsram_we_n};
			{e_cpu_di, e_irq_n} = {dlh_do, dlh_irq_n};
		end else begin
			e_rom_addr = rom_addr_w'(slot_rom_addr[model_sel]); // zero-extended
			e_rom_ce_n = slot_rom_ce_n[model_sel];
			e_rom_oe_n = slot_rom_oe_n[model_sel];
			e_rom_word = slot_rom_word[model_sel];
			e_bs_addr  = slot_bsram_addr[model_sel];
			e_bs_d     = slot_bsram_d[model_sel];
			e_bs_ce_n  = slot_bsram_ce_n[model_sel];
			e_bs_oe_n  = slot_bsram_oe_n[model_sel];
			e_bs_we_n  = slot_bsram_we_n[model_sel];
			e_cpu_di   = slot_do[model_sel];
			e_irq_n    = slot_irq_n[model_sel];
		end
		if (ss_rom_ovr) begin
			e_rom_addr = ss_rom_addr;
		end
		if (ss_do_ovr) begin
			e_cpu_di = ss_do;
		end else if (msu_sel) begin
			e_cpu_di = msu_do;
		end
		if (ss_bsram_sel) begin
			{e_bs_addr, e_bs_d} = {ss_ext_addr, ss_do};
			{e_bs_ce_n, e_bs_oe_n, e_bs_we_n} = {1'b0, pard_n, pawr_n};
		end
		if (ss_aram_sel) begin
			{e_ar_addr, e_ar_d} = {ss_ext_addr[aram_addr_w-1:0], ss_do};
			{e_ar_ce_n, e_ar_oe_n, e_ar_we_n} = {1'b0, pard_n, pawr_n};
		end else begin
			{e_ar_addr, e_ar_d} = {aram_core_addr, aram_core_d};
			{e_ar_ce_n, e_ar_oe_n, e_ar_we_n} = {aram_core_ce_n, aram_core_oe_n, aram_core_we_n};
		end
		e_ss_avail = (rom_type[7:4] == 4'h0) || (rom_type[7:6] == 2'b10) ||
			map_active[idx_sa1] || map_active[idx_gsu];
		e_turbo = !(map_active[idx_sa1] || map_active[idx_sdd1] || ss_busy);
		check_value("rom_addr", 32'(rom_addr), 32'(e_rom_addr));
		check_value("rom_ce_n", 32'(rom_ce_n), 32'(e_rom_ce_n));
		check_value("rom_oe_n", 32'(rom_oe_n), 32'(e_rom_oe_n));
		check_value("rom_word", 32'(rom_word), 32'(e_rom_word));
		check_value("bsram_addr", 32'(bsram_addr), 32'(e_bs_addr));
		check_value("bsram_d", 32'(bsram_d), 32'(e_bs_d));
		check_value("bsram_ce_n", 32'(bsram_ce_n), 32'(e_bs_ce_n));
		check_value("bsram_oe_n", 32'(bsram_oe_n), 32'(e_bs_oe_n));
		check_value("bsram_we_n", 32'(bsram_we_n), 32'(e_bs_we_n));
		check_value("aram_addr", 32'(aram_addr), 32'(e_ar_addr));
		check_value("aram_d", 32'(aram_d), 32'(e_ar_d));
		check_value("aram_ce_n", 32'(aram_ce_n), 32'(e_ar_ce_n));
		check_value("aram_oe_n", 32'(aram_oe_n), 32'(e_ar_oe_n));
		check_value("aram_we_n", 32'(aram_we_n), 32'(e_ar_we_n));
		check_value("cpu_di", 32'(cpu_di), 32'(e_cpu_di));
		check_value("irq_n", 32'(irq_n), 32'(e_irq_n));
		check_value("ss_avail", 32'(ss_avail), 32'(e_ss_avail));
		check_value("turbo_allow", 32'(turbo_allow), 32'(e_turbo));
	endtask

	initial begin
		#(timeout_ns);
		$display("watchdog: the test did not finish within %0d ns", timeout_ns);
		$display("Verification failed");
		$fatal(1, "timeout");
	end

	initial begin
		lfsr_state  = 32'ha7881219;
		model_sel   = sel_dlh;
		rst_n       = 1'b0;
		map_active  = '0;
		rom_type    = '0;
		ss_busy     = 1'b0;
		{dlh_rom_addr, dlh_rom_ce_n, dlh_rom_oe_n, dlh_rom_word} = '1;
		{dlh_bsram_addr, dlh_bsram_d, dlh_bsram_ce_n, dlh_bsram_oe_n, dlh_bsram_we_n} = '1;
		{dlh_do, dlh_irq_n} = '1;
		{slot_rom_addr, slot_rom_ce_n, slot_rom_oe_n, slot_rom_word} = '1;
		{slot_bsram_addr, slot_bsram_d, slot_bsram_ce_n, slot_bsram_oe_n} = '1;
		{slot_bsram_we_n, slot_do, slot_irq_n} = '1;
		{msu_sel, ss_do_ovr, ss_rom_ovr, ss_bsram_sel, ss_aram_sel} = '0;
		{msu_do, ss_do, ss_rom_addr, ss_ext_addr} = '0;
		{pard_n, pawr_n} = 2'b11;
		{aram_core_addr, aram_core_d} = '0;
		{aram_core_ce_n, aram_core_oe_n, aram_core_we_n} = 3'b111;
		repeat (reset_cycles) @(posedge mclk);
		for (int cycle = 0; cycle < num_cycles; cycle++) begin
			#1;
			if (cycle == 0) begin
				rst_n = 1'b1;
			end
			drive_inputs(cycle);
			#2; // settled well before the next edge
			check_outputs();
			model_sel = decode_sel(map_active); // taken at the coming edge
			@(posedge mclk);
		end
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
hw/cart_pkg.sv
hw/mem_bus_if.sv
hw/map_control.sv
hw/map_onehot_mux.sv
hw/cart_port_select.sv
hw/ss_mem_override.sv
hw/cart_bus_top.sv
verification/clk_gen.sv
verification/cart_bus_properties.sv
verification/cart_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cart_bus_tb -f filelist.f -o cart_bus_sim \
	|| { echo "build failed"; exit 1; }

./obj_dir/cart_bus_sim | tee /dev/stderr | grep -q "Verification passed" \
	&& { echo "simulation ok"; exit 0; } \
	|| { echo "simulation did not pass"; exit 1; }
